/* sadPipe.f */
common/sadPkg.sv
src/sadRegFile.sv
src/sadConfig.sv
sad/sadDiffStage.sv
sad/sadSumStage.sv
src/sadWriteback.sv
src/sadPipe.sv
bench/sadPipeTb.sv

/* Bender.yml */
package:
  name: sad_pipe

sources:
  # Shared package first
  - common/sadPkg.sv
  - src/sadRegFile.sv
  - src/sadConfig.sv
  - sad/sadDiffStage.sv
  - sad/sadSumStage.sv
  - src/sadWriteback.sv
  - src/sadPipe.sv

  - target: simulation
    files:
      - bench/sadPipeTb.sv

/* bench/sadPipeTb.sv */
`timescale 1ns/1ps

module sadPipeTb;
        import sadPkg::*;

        localparam int Period       = 100;
        localparam int ResetCycles  = 8;
        // Instructions issued over all six tests
        localparam int TotalOps     = 53;
        // Worst case per instruction including operand loads and drain
        localparam int CyclesPerOp  = 8;
        localparam int MarginCycles = 50;

        // Expected writeback and the cycle it is due in
        typedef struct packed {
                int      due;
                regIdx_t rd;
                word_t   data;
        } wbExp_t;

        logic      Clk = 1'b0;
        logic      rst;
        sadIssue_t issue;
        logic      hostWrite;
        regIdx_t   hostReg;
        word_t     hostData;
        logic      cfgWrite;
        sadCfg_t   cfgData;
        wbBus_t    wb;

        // Model state mirroring what software has written
        word_t     modelRegs [32];
        sadCfg_t   modelCfg = '{laneMask: 4'hF, satEnable: 1'b0};
        wbExp_t    expQ [$];
        wbExp_t    headExp;

        int        seed        = 35780;
        int        edgeCount   = 0;
        int        issuedCount = 0;
        int        checkCount  = 0;
        int        errorCount  = 0;
        int        testChecks  = 0;
        int        testErrors  = 0;
        logic      checkOn     = 1'b0;

        sadPipe #(
                .REG_COUNT (32)
        ) i_dut (
                .Clk       (Clk),
                .rst       (rst),
                .issue     (issue),
                .hostWrite (hostWrite),
                .hostReg   (hostReg),
                .hostData  (hostData),
                .cfgWrite  (cfgWrite),
                .cfgData   (cfgData),
                .wb        (wb)
        );

        always #(Period / 2) Clk = ~Clk;

        // Rising edges seen so far
        always @(posedge Clk) edgeCount <= edgeCount + 1;

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        function automatic word_t modelRead(regIdx_t idx);
                return (idx == '0) ? '0 : modelRegs[idx];
        endfunction

        // Result straight from the instruction rules
        function automatic word_t refResult(sadOp_t opKind, word_t a, word_t b, word_t c,
                                            sadCfg_t cfgNow);
                longint total;
                int     diff;
                total = 0;
                if (opKind == ADD)
                        return a + b;
                if (opKind == SUB)
                        return a - b;
                for (int i = 0; i < NUM_LANES; i++) begin
                        diff = int'(a[8*i +: 8]) - int'(b[8*i +: 8]);
                        if (diff < 0)
                                diff = -diff;
                        if (cfgNow.laneMask[i])
                                total += diff;
                end
                // Old rd joins in for the accumulating form
                if (opKind == SADA)
                        total += longint'({32'h0, c});
                if (total > 64'hFFFF_FFFF && cfgNow.satEnable)
                        return '1;
                return word_t'(total);
        endfunction

        //////////////////////////////////////////////////
        // Stimulus tasks
        //////////////////////////////////////////////////

        // Drive point 1 ns past the rising edge
        task automatic nextCycle();
                @(posedge Clk);
                #1;
        endtask

        task automatic hostLoad(input regIdx_t idx, input word_t data);
                hostWrite = 1'b1;
                hostReg   = idx;
                hostData  = data;
                // r0 keeps reading zero
                if (idx != '0)
                        modelRegs[idx] = data;
                nextCycle();
                hostWrite = 1'b0;
        endtask

        task automatic writeConfig(input laneMask_t mask, input logic sat);
                cfgWrite = 1'b1;
                cfgData  = '{laneMask: mask, satEnable: sat};
                modelCfg = cfgData;
                nextCycle();
                cfgWrite = 1'b0;
        endtask

        task automatic issueOp(input sadOp_t opKind, input regIdx_t srcA, input regIdx_t srcB,
                               input regIdx_t dest);
                wbExp_t entry;
                // Sampled at the next edge and on wb three edges later
                entry.due  = edgeCount + 3;
                entry.rd   = dest;
                entry.data = refResult(opKind, modelRead(srcA), modelRead(srcB),
                                       modelRead(dest), modelCfg);
                expQ.push_back(entry);
                if (dest != '0)
                        modelRegs[dest] = entry.data;
                issue = '{valid: 1'b1, op: opKind, rs: srcA, rt: srcB, rd: dest};
                issuedCount++;
                nextCycle();
                issue.valid = 1'b0;
        endtask

        // Until every expected writeback has been seen
        task automatic waitIdle();
                while (expQ.size() != 0)
                        nextCycle();
        endtask

        task automatic finishTest(input string name);
                waitIdle();
                $display("%-24s %0d checks, %0d errors", name,
                         checkCount - testChecks, errorCount - testErrors);
                testChecks = checkCount;
                testErrors = errorCount;
        endtask

        //////////////////////////////////////////////////
        // Compare
        //////////////////////////////////////////////////

        // Mid-cycle where wb is stable
        always @(negedge Clk) begin
                if (checkOn) begin
                        if (expQ.size() != 0 && expQ[0].due == edgeCount) begin
                                headExp = expQ.pop_front();
                                checkCount++;
                                assert (wb.valid === 1'b1) else begin
                                        $display("Missing writeback for r%0d at cycle %0d",
                                                 headExp.rd, edgeCount);
                                        errorCount++;
                                end
                                if (wb.valid === 1'b1) begin
                                        assert (wb.rd === headExp.rd) else begin
                                                $display("MISMATCH wb.rd: expected %h, got %h",
                                                         headExp.rd, wb.rd);
                                                errorCount++;
                                        end
                                        assert (wb.data === headExp.data) else begin
                                                $display("MISMATCH wb.data: expected %h, got %h",
                                                         headExp.data, wb.data);
                                                errorCount++;
                                        end
                                end
                        end else begin
                                // Nothing due this cycle
                                assert (wb.valid === 1'b0) else begin
                                        $display("Unexpected writeback to r%0d at cycle %0d",
                                                 wb.rd, edgeCount);
                                        errorCount++;
                                end
                        end
                end
        end

        // Watchdog
        initial begin
                #((ResetCycles + TotalOps * CyclesPerOp + MarginCycles) * Period);
                $display("Timeout: run did not finish in time, %0d writebacks still pending",
                         expQ.size());
                $display("SOME TESTS FAILED");
                $finish;
        end

        //////////////////////////////////////////////////
        // Test sequence
        //////////////////////////////////////////////////

        initial begin
                word_t     rnd;
                laneMask_t maskList [5];
                maskList  = '{4'b0001, 4'b0110, 4'b1010, 4'b0000, 4'b1111};
                rst       = 1'b1;
                // Issue held valid through reset so the pipe must drop it
                issue     = '{valid: 1'b1, op: ADD, rs: '0, rt: '0, rd: '0};
                hostWrite = 1'b0;
                hostReg   = '0;
                hostData  = '0;
                cfgWrite  = 1'b0;
                cfgData   = '0;
                repeat (ResetCycles) nextCycle();
                rst     = 1'b0;
                issue   = '0;
                checkOn = 1'b1;

                // Quiet bus then first ADD
                repeat (3) nextCycle();
                hostLoad(5'd1, $random(seed));
                hostLoad(5'd2, $random(seed));
                issueOp(ADD, 5'd1, 5'd2, 5'd3);
                finishTest("reset");

                for (int i = 0; i < 6; i++) begin
                        hostLoad(5'd4, $random(seed));
                        hostLoad(5'd5, $random(seed));
                        issueOp(ADD, 5'd4, 5'd5, 5'd6);
                        issueOp(SUB, 5'd4, 5'd5, 5'd7);
                end
                // Wrap both ways
                hostLoad(5'd8, 32'hFFFF_FFFF);
                hostLoad(5'd9, 32'h0000_0002);
                issueOp(ADD, 5'd8, 5'd9, 5'd10);
                issueOp(SUB, 5'd9, 5'd8, 5'd11);
                // r0 shows on wb but never sticks
                issueOp(ADD, 5'd8, 5'd9, 5'd0);
                hostLoad(5'd0, 32'hDEAD_BEEF);
                waitIdle();
                issueOp(ADD, 5'd0, 5'd9, 5'd12);
                finishTest("add/sub");

                // Default mask after reset is all lanes
                for (int i = 0; i < 8; i++) begin
                        hostLoad(5'd13, $random(seed));
                        hostLoad(5'd14, $random(seed));
                        issueOp(SAD, 5'd13, 5'd14, 5'd23);
                end
                for (int i = 15; i <= 20; i++)
                        hostLoad(regIdx_t'(i), $random(seed));
                // 0 against 255 in every lane
                hostLoad(5'd21, 32'h00FF_00FF);
                hostLoad(5'd22, 32'hFF00_FF00);
                // Back to back with one writeback per cycle
                issueOp(SAD, 5'd13, 5'd14, 5'd23);
                issueOp(SAD, 5'd15, 5'd16, 5'd24);
                issueOp(SAD, 5'd17, 5'd18, 5'd25);
                issueOp(SAD, 5'd19, 5'd20, 5'd26);
                issueOp(SAD, 5'd21, 5'd22, 5'd27);
                issueOp(ADD, 5'd21, 5'd22, 5'd28);
                finishTest("sad all lanes");

                // Last entry restores all lanes
                for (int i = 0; i < 5; i++) begin
                        writeConfig(maskList[i], 1'b0);
                        issueOp(SAD, 5'd13, 5'd14, 5'd23);
                        issueOp(SAD, 5'd21, 5'd22, 5'd24);
                end
                finishTest("lane mask");

                // Overflow wrapping first
                writeConfig(4'hF, 1'b0);
                hostLoad(5'd28, 32'hFFFF_FF00);
                hostLoad(5'd29, 32'h0000_0000);
                hostLoad(5'd30, 32'hFFFF_FFFF);
                issueOp(SADA, 5'd29, 5'd30, 5'd28);
                waitIdle();
                // Then clamped
                writeConfig(4'hF, 1'b1);
                hostLoad(5'd28, 32'hFFFF_FF00);
                issueOp(SADA, 5'd29, 5'd30, 5'd28);
                waitIdle();
                hostLoad(5'd27, 32'h0000_0100);
                issueOp(SADA, 5'd13, 5'd14, 5'd27);
                waitIdle();
                // Random mask and clamp near the top of the range
                for (int i = 0; i < 4; i++) begin
                        rnd = $random(seed);
                        writeConfig(rnd[3:0], rnd[4]);
                        hostLoad(5'd13, $random(seed));
                        hostLoad(5'd14, $random(seed));
                        rnd = $random(seed);
                        hostLoad(5'd27, 32'hFFFF_FC00 + (rnd & 32'h3FF));
                        issueOp(SADA, 5'd13, 5'd14, 5'd27);
                        waitIdle();
                end
                writeConfig(4'hF, 1'b0);
                finishTest("sada saturation");

                // Each step reads what the step before wrote back
                hostLoad(5'd1, $random(seed));
                hostLoad(5'd2, $random(seed));
                issueOp(ADD, 5'd1, 5'd2, 5'd3);
                waitIdle();
                issueOp(SUB, 5'd3, 5'd1, 5'd4);
                waitIdle();
                issueOp(SAD, 5'd3, 5'd4, 5'd5);
                waitIdle();
                issueOp(SADA, 5'd3, 5'd1, 5'd5);
                waitIdle();
                issueOp(ADD, 5'd5, 5'd4, 5'd6);
                finishTest("writeback to regfile");

                $display("Totals: %0d issued, %0d checked, %0d errors",
                         issuedCount, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

/* src/sadPipe.sv */
`timescale 1ns/1ps

module sadPipe #(
        parameter int REG_COUNT = 32
) (
        input  logic              Clk,
        input  logic              rst,
        input  sadPkg::sadIssue_t issue,
        input  logic              hostWrite,
        input  sadPkg::regIdx_t   hostReg,
        input  sadPkg::word_t     hostData,
        input  logic              cfgWrite,
        input  sadPkg::sadCfg_t   cfgData,
        output sadPkg::wbBus_t    wb
);
        import sadPkg::*;

        // Operands from the register file
        word_t      opA;
        word_t      opB;
        word_t      opC;
        // Stage registers
        sad1Stage_t sad1;
        sad2Stage_t sad2;
        sadCfg_t    cfg;

        //////////////////////////////////////////////////
        // Operand fetch and writeback target
        //////////////////////////////////////////////////

        sadRegFile #(
                .REG_COUNT (REG_COUNT)
        ) i_regFile (
                .Clk       (Clk),
                .rst       (rst),
                .rs        (issue.rs),
                .rt        (issue.rt),
                .rd        (issue.rd),
                .opA       (opA),
                .opB       (opB),
                .opC       (opC),
                .wb        (wb),
                .hostWrite (hostWrite),
                .hostReg   (hostReg),
                .hostData  (hostData)
        );

        // Lane mask and clamp flag
        sadConfig i_config (
                .Clk      (Clk),
                .rst      (rst),
                .cfgWrite (cfgWrite),
                .cfgData  (cfgData),
                .cfg      (cfg)
        );

        //////////////////////////////////////////////////
        // SAD1, SAD2, W
        //////////////////////////////////////////////////

        sadDiffStage i_diffStage (
                .Clk   (Clk),
                .rst   (rst),
                .issue (issue),
                .opA   (opA),
                .opB   (opB),
                .opC   (opC),
                .sad1  (sad1)
        );

        sadSumStage i_sumStage (
                .Clk  (Clk),
                .rst  (rst),
                .sad1 (sad1),
                .cfg  (cfg),
                .sad2 (sad2)
        );

        // Feeds both the register file and the output port
        sadWriteback i_writeback (
                .Clk  (Clk),
                .rst  (rst),
                .sad2 (sad2),
                .wb   (wb)
        );

endmodule

/* src/sadWriteback.sv */
`timescale 1ns/1ps

module sadWriteback (
        input  logic               Clk,
        input  logic               rst,
        input  sadPkg::sad2Stage_t sad2,
        output sadPkg::wbBus_t     wb
);

        //////////////////////////////////////////////////
        // SAD2 to W register
        //////////////////////////////////////////////////

        // Last stage before the register file
        // wb.valid rises three cycles after issue
        always_ff @(posedge Clk) begin
                if (rst) begin
                        // Drop anything in flight
                        wb.valid <= 1'b0;
                end else begin
                        wb.valid <= sad2.valid;
                end

                // Destination and value pass through untouched
                wb.rd   <= sad2.rd;
                wb.data <= sad2.result;
        end

        // r0 writes still show up here,
        // the register file is what discards them

endmodule

/* sad/sadSumStage.sv */
`timescale 1ns/1ps

module sadSumStage (
        input  logic               Clk,
        input  logic               rst,
        input  sadPkg::sad1Stage_t sad1,
        input  sadPkg::sadCfg_t    cfg,
        output sadPkg::sad2Stage_t sad2
);
        import sadPkg::*;

        // Lane sum tops out at NUM_LANES * 255
        localparam int LaneSumW = $bits(lane_t) + $clog2(NUM_LANES);
        // One extra bit to catch the carry out
        localparam int AccW     = $bits(word_t) + 1;

        logic [LaneSumW-1:0] laneSum;
        word_t               accBase;
        logic [AccW-1:0]     accSum;
        word_t               sadResult;
        word_t               result;

        //////////////////////////////////////////////////
        // Masked lane sum
        //////////////////////////////////////////////////

        // Disabled lanes count as zero, mask of 0 gives 0
        always_comb begin
                laneSum = '0;
                for (int i = 0; i < NUM_LANES; i++) begin
                        if (cfg.laneMask[i])
                                laneSum = laneSum + LaneSumW'(sad1.absDiff[i]);
                end
        end

        //////////////////////////////////////////////////
        // Accumulate and clamp
        //////////////////////////////////////////////////

        always_comb begin
                // Plain SAD starts from zero
                accBase = (sad1.op == SADA) ? sad1.accBase : '0;
                accSum  = AccW'(accBase) + AccW'(laneSum);

                // Carry out means the word overflowed
                if (accSum[AccW-1] && cfg.satEnable)
                        sadResult = '1;
                else
                        sadResult = accSum[AccW-2:0];
        end

        // Result select
        always_comb begin
                if (sad1.op == SAD || sad1.op == SADA)
                        result = sadResult;
                else
                        result = sad1.aluResult;
        end

        //////////////////////////////////////////////////
        // SAD2 register
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst)
                        sad2.valid <= 1'b0;
                else
                        sad2.valid <= sad1.valid;

                sad2.rd     <= sad1.rd;
                sad2.result <= result;
        end

endmodule

/* sad/sadDiffStage.sv */
`timescale 1ns/1ps

module sadDiffStage (
        input  logic               Clk,
        input  logic               rst,
        input  sadPkg::sadIssue_t  issue,
        input  sadPkg::word_t      opA,
        input  sadPkg::word_t      opB,
        input  sadPkg::word_t      opC,
        output sadPkg::sad1Stage_t sad1
);
        import sadPkg::*;

        // Operands viewed as byte lanes, lane 0 in the low byte
        lane_t [NUM_LANES-1:0] lanesA;
        lane_t [NUM_LANES-1:0] lanesB;
        lane_t [NUM_LANES-1:0] laneDiff;
        word_t                 aluResult;

        assign lanesA = opA;
        assign lanesB = opB;

        //////////////////////////////////////////////////
        // Per-lane absolute difference
        //////////////////////////////////////////////////

        // Larger minus smaller, never goes negative
        always_comb begin
                for (int i = 0; i < NUM_LANES; i++) begin
                        if (lanesA[i] > lanesB[i])
                                laneDiff[i] = lanesA[i] - lanesB[i];
                        else
                                laneDiff[i] = lanesB[i] - lanesA[i];
                end
        end

        //////////////////////////////////////////////////
        // ALU path
        //////////////////////////////////////////////////

        // Both wrap modulo 2^32
        // SAD ops also land here, result dropped in SAD2
        always_comb begin
                if (issue.op == SUB)
                        aluResult = opA - opB;
                else
                        aluResult = opA + opB;
        end

        //////////////////////////////////////////////////
        // SAD1 register
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst)
                        sad1.valid <= 1'b0;
                else
                        sad1.valid <= issue.valid;

                sad1.op        <= issue.op;
                sad1.rd        <= issue.rd;
                sad1.absDiff   <= laneDiff;
                sad1.aluResult <= aluResult;
                // Old rd, kept for SADA accumulation
                sad1.accBase   <= opC;
        end

endmodule

/* src/sadConfig.sv */
`timescale 1ns/1ps

module sadConfig (
        input  logic            Clk,
        input  logic            rst,
        input  logic            cfgWrite,
        input  sadPkg::sadCfg_t cfgData,
        output sadPkg::sadCfg_t cfg
);
        import sadPkg::*;

        // Every lane on, wrap on overflow
        localparam sadCfg_t CfgDefault = '{
                laneMask:  '1,
                satEnable: 1'b0
        };

        //////////////////////////////////////////////////
        // Config register
        //////////////////////////////////////////////////

        // Read combinationally by SAD2, so a write at edge j
        // steers the instruction registered at j+1
        always_ff @(posedge Clk) begin
                if (rst) begin
                        cfg <= CfgDefault;
                end else if (cfgWrite) begin
                        // Mask and clamp flag load together
                        cfg <= cfgData;
                end
        end

endmodule

/* src/sadRegFile.sv */
`timescale 1ns/1ps

module sadRegFile #(
        parameter int REG_COUNT = 32
) (
        input  logic            Clk,
        input  logic            rst,
        input  sadPkg::regIdx_t rs,
        input  sadPkg::regIdx_t rt,
        input  sadPkg::regIdx_t rd,
        output sadPkg::word_t   opA,
        output sadPkg::word_t   opB,
        output sadPkg::word_t   opC,
        input  sadPkg::wbBus_t  wb,
        input  logic            hostWrite,
        input  sadPkg::regIdx_t hostReg,
        input  sadPkg::word_t   hostData
);
        import sadPkg::*;

        word_t regArray [REG_COUNT];

        // r0 and anything past the array top never take a write
        function automatic logic isWritable(regIdx_t idx);
                return (idx != '0) && (int'(idx) < REG_COUNT);
        endfunction

        // r0 is hardwired to zero
        function automatic word_t readReg(regIdx_t idx);
                if (idx == '0 || int'(idx) >= REG_COUNT)
                        return '0;
                return regArray[idx];
        endfunction

        //////////////////////////////////////////////////
        // Read ports
        //////////////////////////////////////////////////

        // Straight off the issue fields, no read latency
        always_comb begin
                opA = readReg(rs);
                opB = readReg(rt);
                opC = readReg(rd);
        end

        //////////////////////////////////////////////////
        // Write ports
        //////////////////////////////////////////////////

        // Host write first, writeback second
        // so wb takes the register on a collision
        always_ff @(posedge Clk) begin
                if (!rst) begin
                        if (hostWrite && isWritable(hostReg))
                                regArray[hostReg] <= hostData;
                        if (wb.valid && isWritable(wb.rd))
                                regArray[wb.rd] <= wb.data;
                end
        end

endmodule

/* common/sadPkg.sv */
package sadPkg;

        //////////////////////////////////////////////////
        // Widths
        //////////////////////////////////////////////////

        // Bytes per word, one pixel each
        localparam int NUM_LANES = 4;

        typedef logic [31:0]            word_t;
        typedef logic [4:0]             regIdx_t;
        typedef logic [7:0]             lane_t;
        typedef logic [NUM_LANES-1:0]   laneMask_t;

        //////////////////////////////////////////////////
        // Operations
        //////////////////////////////////////////////////

        typedef enum logic [1:0] {
                ADD  = 2'd0,
                SUB  = 2'd1,
                SAD  = 2'd2,
                SADA = 2'd3
        } sadOp_t;

        // One instruction at issue
        typedef struct packed {
                logic    valid;
                sadOp_t  op;
                regIdx_t rs;
                regIdx_t rt;
                regIdx_t rd;
        } sadIssue_t;

        // Lane enables and clamp control for the summing stage
        typedef struct packed {
                laneMask_t laneMask;
                logic      satEnable;
        } sadCfg_t;

        //////////////////////////////////////////////////
        // Stage registers
        //////////////////////////////////////////////////

        typedef struct packed {
                logic                   valid;
                sadOp_t                 op;
                regIdx_t                rd;
                lane_t [NUM_LANES-1:0]  absDiff;
                word_t                  aluResult;
                // Old rd value, only used by SADA
                word_t                  accBase;
        } sad1Stage_t;

        typedef struct packed {
                logic    valid;
                regIdx_t rd;
                word_t   result;
        } sad2Stage_t;

        // Writeback bus, also the top-level result port
        typedef struct packed {
                logic    valid;
                regIdx_t rd;
                word_t   data;
        } wbBus_t;

endpackage
